// ==== filelist.f ====
+incdir+test
source/winRatePkg.sv
source/deckMask.sv
source/pairEnumerator.sv
source/handEvaluator.sv
source/showdownJudge.sv
source/winAccumulator.sv
source/winRate.sv
test/winRateTb.sv

// ==== source/deckMask.sv ====
`timescale 1ns/100ps

module deckMask
    import winRatePkg::*;
(
    input  logic [4*NumHole-1:0] holdNum,
    input  logic [2*NumHole-1:0] holdSuit,
    input  logic [4*NumPub-1:0]  pubNum,
    input  logic [2*NumPub-1:0]  pubSuit,
    output deckMaskT             freeMask
);

    // hole cards first, then the public cards
    cardIdxT knownIdx [NumHole+NumPub];

    function automatic cardIdxT cardIndex(rankT rank, suitT suit);
        return cardIdxT'(suit) * cardIdxT'(NumRanks) + cardIdxT'(rank) - cardIdxT'(2);
    endfunction

    always_comb begin
        for (int h = 0; h < NumHole; h++) begin
            knownIdx[h] = cardIndex(holdNum[4*h +: 4], holdSuit[2*h +: 2]);
        end
        for (int q = 0; q < NumPub; q++) begin
            knownIdx[NumHole+q] = cardIndex(pubNum[4*q +: 4], pubSuit[2*q +: 2]);
        end
    end

    // start from a full deck and knock out every dealt card
    always_comb begin
        freeMask = '1;
        for (int k = 0; k < NumHole + NumPub; k++) begin
            freeMask[knownIdx[k]] = 1'b0;
        end
    end

endmodule

// ==== source/handEvaluator.sv ====
`timescale 1ns/100ps

module handEvaluator
    import winRatePkg::*;
(
    input  logic [7:0]          holeNum,
    input  logic [3:0]          holeSuit,
    input  logic [4*NumPub-1:0] pubNum,
    input  logic [2*NumPub-1:0] pubSuit,
    input  rankT                turnRank,
    input  suitT                turnSuit,
    input  rankT                riverRank,
    input  suitT                riverSuit,
    output categoryT            category
);

    localparam int NumCards = NumPub + 4;

    rankT ranks [NumCards];
    suitT suits [NumCards];
    // indexed by rank value, slots 0 and 15 stay empty
    logic [2:0] rankCount [16];
    logic [2:0] suitCount [4];
    // bit r set when rank r is held, bit 1 mirrors the ace
    logic [15:0] present;
    logic [15:0] suited [4];
    logic [3:0] numPairs;
    logic [3:0] numTrips;
    logic quads;
    logic flush;
    logic straight;
    logic straightFlush;

    function automatic logic hasStraight(logic [15:0] m);
        logic found;
        found = 1'b0;
        // lowest card of the run goes from ace-low up to ten
        for (int lo = 1; lo <= 10; lo++) begin
            if (&m[lo +: 5]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // gather the seven cards
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            ranks[c] = holeNum[4*c +: 4];
            suits[c] = holeSuit[2*c +: 2];
        end
        for (int c = 0; c < NumPub; c++) begin
            ranks[2+c] = pubNum[4*c +: 4];
            suits[2+c] = pubSuit[2*c +: 2];
        end
        ranks[NumCards-2] = turnRank;
        suits[NumCards-2] = turnSuit;
        ranks[NumCards-1] = riverRank;
        suits[NumCards-1] = riverSuit;
    end

    // ====================
    // histograms
    // ====================
    always_comb begin
        rankCount = '{default: '0};
        suitCount = '{default: '0};
        present = '0;
        suited = '{default: '0};
        for (int c = 0; c < NumCards; c++) begin
            rankCount[ranks[c]] = rankCount[ranks[c]] + 3'd1;
            suitCount[suits[c]] = suitCount[suits[c]] + 3'd1;
            present[ranks[c]] = 1'b1;
            suited[suits[c]][ranks[c]] = 1'b1;
        end
        // ace plays low as well
        present[1] = present[14];
        for (int s = 0; s < 4; s++) begin
            suited[s][1] = suited[s][14];
        end
    end

    always_comb begin
        numPairs = '0;
        numTrips = '0;
        quads = 1'b0;
        for (int r = 2; r <= 14; r++) begin
            numPairs = numPairs + 4'(rankCount[r] == 3'd2);
            numTrips = numTrips + 4'(rankCount[r] == 3'd3);
            quads = quads | (rankCount[r] == 3'd4);
        end
    end

    always_comb begin
        flush = 1'b0;
        straightFlush = 1'b0;
        for (int s = 0; s < 4; s++) begin
            flush = flush | (suitCount[s] >= 3'd5);
            straightFlush = straightFlush | hasStraight(suited[s]);
        end
        straight = hasStraight(present);
    end

    // ====================
    // best category
    // ====================
    always_comb begin
        if (straightFlush) begin
            category = StraightFlush;
        end else if (quads) begin
            category = FourKind;
        end else if (numTrips >= 4'd2 || (numTrips != '0 && numPairs != '0)) begin
            category = FullHouse;
        end else if (flush) begin
            category = Flush;
        end else if (straight) begin
            category = Straight;
        end else if (numTrips != '0) begin
            category = ThreeKind;
        end else if (numPairs >= 4'd2) begin
            category = TwoPair;
        end else if (numPairs != '0) begin
            category = OnePair;
        end else begin
            category = HighCard;
        end
    end

endmodule

// ==== source/pairEnumerator.sv ====
`timescale 1ns/100ps

module pairEnumerator
    import winRatePkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [4*NumHole-1:0] in_hole_num,
    input  logic [2*NumHole-1:0] in_hole_suit,
    input  logic [4*NumPub-1:0]  in_pub_num,
    input  logic [2*NumPub-1:0]  in_pub_suit,
    input  deckMaskT             freeMask,
    output logic [4*NumHole-1:0] holdNum,
    output logic [2*NumHole-1:0] holdSuit,
    output logic [4*NumPub-1:0]  pubNum,
    output logic [2*NumPub-1:0]  pubSuit,
    output rankT                 turnRank,
    output suitT                 turnSuit,
    output rankT                 riverRank,
    output suitT                 riverSuit,
    output logic                 pairValid,
    output logic                 sweepStart,
    output logic                 sweepDone
);

    logic sweeping;
    logic capture;
    // turnMask: free cards from the current turn card upward
    // riverMask: free cards still to pair with that turn card
    deckMaskT turnMask;
    deckMaskT riverMask;
    deckMaskT curTurn;
    deckMaskT curRiver;
    deckMaskT riverRest;
    deckMaskT nextTurn;
    deckMaskT nextRiver;
    cardIdxT turnIdx;
    cardIdxT riverIdx;

    function automatic deckMaskT dropLowest(deckMaskT m);
        return m & (m - 1'b1);
    endfunction

    function automatic cardIdxT lowestIdx(deckMaskT m);
        cardIdxT idx;
        idx = '0;
        for (int i = DeckSize - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = cardIdxT'(i);
            end
        end
        return idx;
    endfunction

    function automatic suitT idxSuit(cardIdxT idx);
        if (idx >= cardIdxT'(3 * NumRanks)) return 2'd3;
        if (idx >= cardIdxT'(2 * NumRanks)) return 2'd2;
        if (idx >= cardIdxT'(NumRanks)) return 2'd1;
        return 2'd0;
    endfunction

    function automatic rankT idxRank(cardIdxT idx);
        cardIdxT offset;
        offset = idx - cardIdxT'(idxSuit(idx)) * cardIdxT'(NumRanks);
        return rankT'(offset + cardIdxT'(2));
    endfunction

    assign capture = in_valid && !sweeping;
    assign pairValid = sweeping;

    // ====================
    // pair walk
    // ====================
    // first sweep cycle reads the mask straight from deckMask
    always_comb begin
        curTurn = sweepStart ? freeMask : turnMask;
        curRiver = sweepStart ? dropLowest(freeMask) : riverMask;
        riverRest = dropLowest(curRiver);
        nextTurn = dropLowest(curTurn);
        nextRiver = dropLowest(nextTurn);
    end

    // last pair: row exhausted and nothing left above the next turn card
    assign sweepDone = sweeping && (riverRest == '0) && (nextRiver == '0);

    always_ff @(posedge clk) begin
        if (sweeping) begin
            if (riverRest == '0) begin
                turnMask <= nextTurn;
                riverMask <= nextRiver;
            end else begin
                turnMask <= curTurn;
                riverMask <= riverRest;
            end
        end
    end

    assign turnIdx = lowestIdx(curTurn);
    assign riverIdx = lowestIdx(curRiver);
    assign turnRank = idxRank(turnIdx);
    assign turnSuit = idxSuit(turnIdx);
    assign riverRank = idxRank(riverIdx);
    assign riverSuit = idxSuit(riverIdx);

    // ====================
    // capture and state
    // ====================
    always_ff @(posedge clk) begin
        if (capture) begin
            holdNum <= in_hole_num;
            holdSuit <= in_hole_suit;
            pubNum <= in_pub_num;
            pubSuit <= in_pub_suit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweeping <= 1'b0;
            sweepStart <= 1'b0;
        end else begin
            sweepStart <= capture;
            if (capture) begin
                sweeping <= 1'b1;
            end else if (sweepDone) begin
                sweeping <= 1'b0;
            end
        end
    end

endmodule

// ==== source/showdownJudge.sv ====
`timescale 1ns/100ps

module showdownJudge
    import winRatePkg::*;
(
    input  categoryT   category [NumPlayers],
    output winnerMaskT winnerMask,
    output shareT      share
);

    categoryT best;
    winnerMaskT flags;
    logic [3:0] numWinners;

    always_comb begin
        best = HighCard;
        for (int p = 0; p < NumPlayers; p++) begin
            if (category[p] > best) begin
                best = category[p];
            end
        end
    end

    // equal categories tie and split the pot
    always_comb begin
        numWinners = '0;
        for (int p = 0; p < NumPlayers; p++) begin
            flags[p] = (category[p] == best);
            numWinners = numWinners + 4'(flags[p]);
        end
    end

    assign winnerMask = flags;

    // equal split of the pot, always exact
    always_comb begin
        case (numWinners)
            4'd1: share = shareT'(FullShare / 1);
            4'd2: share = shareT'(FullShare / 2);
            4'd3: share = shareT'(FullShare / 3);
            4'd4: share = shareT'(FullShare / 4);
            4'd5: share = shareT'(FullShare / 5);
            4'd6: share = shareT'(FullShare / 6);
            4'd7: share = shareT'(FullShare / 7);
            4'd8: share = shareT'(FullShare / 8);
            4'd9: share = shareT'(FullShare / 9);
            default: share = '0;
        endcase
    end

endmodule

// ==== source/winAccumulator.sv ====
`timescale 1ns/100ps

module winAccumulator
    import winRatePkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sweepStart,
    input  logic                    pairValid,
    input  logic                    sweepDone,
    input  winnerMaskT              winnerMask,
    input  shareT                   share,
    output logic                    out_valid,
    output logic [7*NumPlayers-1:0] out_win_rate
);

    shareT total [NumPlayers];
    shareT addend [NumPlayers];
    shareT quotient [NumPlayers];
    logic [7*NumPlayers-1:0] rateWord;
    // loadRate: totals are final, showRate: rateWord is ready
    logic loadRate;
    logic showRate;

    always_comb begin
        for (int p = 0; p < NumPlayers; p++) begin
            addend[p] = (pairValid && winnerMask[p]) ? share : '0;
            quotient[p] = total[p] / PercentDivisor;
        end
    end

    // ====================
    // share totals
    // ====================
    // first pair of a sweep lands on a cleared total
    always_ff @(posedge clk) begin
        for (int p = 0; p < NumPlayers; p++) begin
            if (sweepStart) begin
                total[p] <= addend[p];
            end else begin
                total[p] <= total[p] + addend[p];
            end
        end
    end

    // ====================
    // rates and output
    // ====================
    always_ff @(posedge clk) begin
        if (loadRate) begin
            for (int p = 0; p < NumPlayers; p++) begin
                rateWord[7*p +: 7] <= rateT'(quotient[p]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loadRate <= 1'b0;
            showRate <= 1'b0;
            out_valid <= 1'b0;
            out_win_rate <= '0;
        end else begin
            loadRate <= sweepDone;
            showRate <= loadRate;
            out_valid <= showRate;
            out_win_rate <= showRate ? rateWord : '0;
        end
    end

endmodule

// ==== source/winRate.sv ====
`timescale 1ns/100ps

module winRate
    import winRatePkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [4*NumHole-1:0]    in_hole_num,
    input  logic [2*NumHole-1:0]    in_hole_suit,
    input  logic [4*NumPub-1:0]     in_pub_num,
    input  logic [2*NumPub-1:0]     in_pub_suit,
    output logic                    out_valid,
    output logic [7*NumPlayers-1:0] out_win_rate
);

    deckMaskT freeMask;
    logic [4*NumHole-1:0] holdNum;
    logic [2*NumHole-1:0] holdSuit;
    logic [4*NumPub-1:0] pubNum;
    logic [2*NumPub-1:0] pubSuit;
    rankT turnRank;
    suitT turnSuit;
    rankT riverRank;
    suitT riverSuit;
    logic pairValid;
    logic sweepStart;
    logic sweepDone;
    categoryT category [NumPlayers];
    winnerMaskT winnerMask;
    shareT share;

    deckMask uDeckMask (
        .holdNum  (holdNum),
        .holdSuit (holdSuit),
        .pubNum   (pubNum),
        .pubSuit  (pubSuit),
        .freeMask (freeMask)
    );

    pairEnumerator uPairEnumerator (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_hole_num  (in_hole_num),
        .in_hole_suit (in_hole_suit),
        .in_pub_num   (in_pub_num),
        .in_pub_suit  (in_pub_suit),
        .freeMask     (freeMask),
        .holdNum      (holdNum),
        .holdSuit     (holdSuit),
        .pubNum       (pubNum),
        .pubSuit      (pubSuit),
        .turnRank     (turnRank),
        .turnSuit     (turnSuit),
        .riverRank    (riverRank),
        .riverSuit    (riverSuit),
        .pairValid    (pairValid),
        .sweepStart   (sweepStart),
        .sweepDone    (sweepDone)
    );

    // player p owns cards 2p and 2p+1
    for (genvar p = 0; p < NumPlayers; p++) begin : gPlayer
        handEvaluator uHandEvaluator (
            .holeNum   (holdNum[8*p +: 8]),
            .holeSuit  (holdSuit[4*p +: 4]),
            .pubNum    (pubNum),
            .pubSuit   (pubSuit),
            .turnRank  (turnRank),
            .turnSuit  (turnSuit),
            .riverRank (riverRank),
            .riverSuit (riverSuit),
            .category  (category[p])
        );
    end

    showdownJudge uShowdownJudge (
        .category   (category),
        .winnerMask (winnerMask),
        .share      (share)
    );

    winAccumulator uWinAccumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .sweepStart   (sweepStart),
        .pairValid    (pairValid),
        .sweepDone    (sweepDone),
        .winnerMask   (winnerMask),
        .share        (share),
        .out_valid    (out_valid),
        .out_win_rate (out_win_rate)
    );

endmodule

// ==== source/winRatePkg.sv ====
package winRatePkg;

    // ====================
    // table setup
    // ====================
    localparam int NumPlayers = 9;
    localparam int NumPub = 3;
    localparam int NumHole = 2 * NumPlayers;
    localparam int NumRanks = 13;
    localparam int DeckSize = 52;

    // ====================
    // card types
    // ====================
    // rank 2..14, ace is 14
    typedef logic [3:0] rankT;
    typedef logic [1:0] suitT;
    // deck index is suit * 13 + rank - 2
    typedef logic [5:0] cardIdxT;
    typedef logic [DeckSize-1:0] deckMaskT;

    // ====================
    // hand scoring
    // ====================
    typedef logic [3:0] categoryT;

    localparam categoryT HighCard = 4'd0;
    localparam categoryT OnePair = 4'd1;
    localparam categoryT TwoPair = 4'd2;
    localparam categoryT ThreeKind = 4'd3;
    localparam categoryT Straight = 4'd4;
    localparam categoryT Flush = 4'd5;
    localparam categoryT FullHouse = 4'd6;
    localparam categoryT FourKind = 4'd7;
    localparam categoryT StraightFlush = 4'd8;

    typedef logic [NumPlayers-1:0] winnerMaskT;

    // ====================
    // pot shares
    // ====================
    // 2520 divides evenly by 1..9 winners, max total 465 * 2520
    typedef logic [20:0] shareT;
    localparam shareT FullShare = 21'd2520;
    // 465 * 2520 / 100
    localparam shareT PercentDivisor = 21'd11718;

    typedef logic [6:0] rateT;

endpackage

// ==== test/winRateModel.svh ====
`ifndef WIN_RATE_MODEL_SVH
`define WIN_RATE_MODEL_SVH

// one 6-bit deck index per card, hole cards 0..17 then board cards 18..20
typedef logic [6*(NumHole+NumPub)-1:0] dealT;

logic [31:0] rngState;

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic int cardRank(input int idx);
    return idx % 13 + 2;
endfunction

function automatic int cardSuit(input int idx);
    return idx / 13;
endfunction

// shuffle a fresh deck and take the top 21 cards
task automatic makeDeal(output dealT deal);
    int deck [52];
    int j;
    int tmp;
    for (int i = 0; i < 52; i++) begin
        deck[i] = i;
    end
    for (int i = 51; i > 0; i--) begin
        rngState = xorshift(rngState);
        j = int'(rngState % (i + 1));
        tmp = deck[i];
        deck[i] = deck[j];
        deck[j] = tmp;
    end
    deal = '0;
    for (int k = 0; k < NumHole + NumPub; k++) begin
        deal[6*k +: 6] = 6'(deck[k]);
    end
endtask

// five ranks in a row, the ace also counts below the deuce
function automatic bit runOfFive(input logic [14:0] seen);
    int run;
    bit found;
    found = 1'b0;
    run = seen[14] ? 1 : 0;
    for (int r = 2; r <= 14; r++) begin
        run = seen[r] ? run + 1 : 0;
        if (run >= 5) begin
            found = 1'b1;
        end
    end
    return found;
endfunction

// category 0 high card up to 8 straight flush, kickers ignored
function automatic int handCategory(input logic [41:0] hand);
    int rankCnt [15];
    int suitCnt [4];
    logic [14:0] rankSeen;
    logic [14:0] suitSeen [4];
    int pairs;
    int trips;
    int quads;
    int r;
    int s;
    bit flush;
    bit straightFlush;
    pairs = 0;
    trips = 0;
    quads = 0;
    flush = 1'b0;
    straightFlush = 1'b0;
    rankSeen = '0;
    for (int i = 0; i < 15; i++) begin
        rankCnt[i] = 0;
    end
    for (int i = 0; i < 4; i++) begin
        suitCnt[i] = 0;
        suitSeen[i] = '0;
    end
    for (int c = 0; c < 7; c++) begin
        r = cardRank(hand[6*c +: 6]);
        s = cardSuit(hand[6*c +: 6]);
        rankCnt[r]++;
        suitCnt[s]++;
        rankSeen[r] = 1'b1;
        suitSeen[s][r] = 1'b1;
    end
    for (int i = 2; i <= 14; i++) begin
        if (rankCnt[i] == 2) pairs++;
        if (rankCnt[i] == 3) trips++;
        if (rankCnt[i] == 4) quads++;
    end
    for (int i = 0; i < 4; i++) begin
        if (suitCnt[i] >= 5) flush = 1'b1;
        if (runOfFive(suitSeen[i])) straightFlush = 1'b1;
    end
    if (straightFlush) return 8;
    if (quads > 0) return 7;
    if (trips >= 2 || (trips > 0 && pairs > 0)) return 6;
    if (flush) return 5;
    if (runOfFive(rankSeen)) return 4;
    if (trips > 0) return 3;
    if (pairs >= 2) return 2;
    if (pairs > 0) return 1;
    return 0;
endfunction

// walk every unused turn/river pair and split 2520 units among the winners
function automatic logic [7*NumPlayers-1:0] expectedRates(input dealT deal);
    logic [51:0] used;
    int total [NumPlayers];
    int cat [NumPlayers];
    logic [41:0] hand;
    int best;
    int winners;
    logic [7*NumPlayers-1:0] rates;
    used = '0;
    for (int k = 0; k < NumHole + NumPub; k++) begin
        used[deal[6*k +: 6]] = 1'b1;
    end
    for (int p = 0; p < NumPlayers; p++) begin
        total[p] = 0;
    end
    for (int t = 0; t < 52; t++) begin
        for (int r = t + 1; r < 52; r++) begin
            if (!used[t] && !used[r]) begin
                best = 0;
                winners = 0;
                for (int p = 0; p < NumPlayers; p++) begin
                    hand[5:0] = deal[12*p +: 6];
                    hand[11:6] = deal[12*p+6 +: 6];
                    hand[29:12] = deal[6*NumHole +: 6*NumPub];
                    hand[35:30] = 6'(t);
                    hand[41:36] = 6'(r);
                    cat[p] = handCategory(hand);
                    if (cat[p] > best) best = cat[p];
                end
                for (int p = 0; p < NumPlayers; p++) begin
                    if (cat[p] == best) winners++;
                end
                for (int p = 0; p < NumPlayers; p++) begin
                    if (cat[p] == best) total[p] += 2520 / winners;
                end
            end
        end
    end
    // 465 pairs * 2520 units / 100
    for (int p = 0; p < NumPlayers; p++) begin
        rates[7*p +: 7] = 7'(total[p] / 11718);
    end
    return rates;
endfunction

`endif

// ==== test/winRateTb.sv ====
`timescale 1ns/100ps

module winRateTb
    import winRatePkg::*;
();

    // capture edge to out_valid edge
    localparam int Latency = 467;
    localparam int NumDeals = 20;
    localparam int TimeoutCycles = NumDeals * 500 + 100;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid;
    logic [4*NumHole-1:0] in_hole_num;
    logic [2*NumHole-1:0] in_hole_suit;
    logic [4*NumPub-1:0] in_pub_num;
    logic [2*NumPub-1:0] in_pub_suit;
    logic out_valid;
    logic [7*NumPlayers-1:0] out_win_rate;

    `include "winRateModel.svh"

    int cycleCount = 0;
    int sentCount = 0;
    int resultCount = 0;
    logic [7*NumPlayers-1:0] expectQ [$];
    int dueQ [$];
    dealT deal;
    dealT other;

    winRate uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_hole_num  (in_hole_num),
        .in_hole_suit (in_hole_suit),
        .in_pub_num   (in_pub_num),
        .in_pub_suit  (in_pub_suit),
        .out_valid    (out_valid),
        .out_win_rate (out_win_rate)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // ====================
    // helpers
    // ====================
    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compareRate(input int player, input rateT got, input rateT expected);
        if (got !== expected) begin
            stopOnError($sformatf("Fail time=%0t signal=out_win_rate[%0d] got=%0d expected=%0d",
                $time, player, got, expected));
        end
    endtask

    task automatic compareValid(input logic got, input logic expected);
        if (got !== expected) begin
            stopOnError($sformatf("Fail time=%0t signal=out_valid got=%b expected=%b",
                $time, got, expected));
        end
    endtask

    // one in_valid pulse driven on the falling edge
    task automatic sendDeal(input dealT d);
        @(negedge clk);
        for (int j = 0; j < NumHole; j++) begin
            in_hole_num[4*j +: 4] = 4'(cardRank(d[6*j +: 6]));
            in_hole_suit[2*j +: 2] = 2'(cardSuit(d[6*j +: 6]));
        end
        for (int q = 0; q < NumPub; q++) begin
            in_pub_num[4*q +: 4] = 4'(cardRank(d[6*(NumHole+q) +: 6]));
            in_pub_suit[2*q +: 2] = 2'(cardSuit(d[6*(NumHole+q) +: 6]));
        end
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic queueResult(input dealT d);
        dueQ.push_back(cycleCount + Latency);
        expectQ.push_back(expectedRates(d));
        sentCount++;
    endtask

    task automatic playDeal(input dealT d);
        sendDeal(d);
        queueResult(d);
        wait (resultCount == sentCount);
    endtask

    // ====================
    // result comparer
    // ====================
    initial begin : resultCheck
        logic [7*NumPlayers-1:0] expected;
        int due;
        int sum;
        forever begin
            @(negedge clk);
            if (out_valid === 1'b1) begin
                if (expectQ.size() == 0) begin
                    stopOnError("out_valid was raised with no deal pending");
                end
                expected = expectQ.pop_front();
                due = dueQ.pop_front();
                if (cycleCount != due) begin
                    stopOnError($sformatf(
                        "Fail time=%0t signal=out_valid cycle got=%0d expected=%0d",
                        $time, cycleCount, due));
                end
                sum = 0;
                for (int p = 0; p < NumPlayers; p++) begin
                    sum += out_win_rate[7*p +: 7];
                end
                if (sum > 100) begin
                    stopOnError($sformatf("the nine rates add up to %0d, more than 100", sum));
                end
                for (int p = 0; p < NumPlayers; p++) begin
                    compareRate(p, out_win_rate[7*p +: 7], expected[7*p +: 7]);
                end
                resultCount++;
                // single-cycle strobe and rates back to zero
                @(negedge clk);
                compareValid(out_valid, 1'b0);
                for (int p = 0; p < NumPlayers; p++) begin
                    compareRate(p, out_win_rate[7*p +: 7], '0);
                end
            end else begin
                for (int p = 0; p < NumPlayers; p++) begin
                    compareRate(p, out_win_rate[7*p +: 7], '0);
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycleCount >= TimeoutCycles);
        stopOnError($sformatf("out_valid never came for every deal within %0d cycles",
            TimeoutCycles));
    end

    // ====================
    // stimulus
    // ====================
    initial begin : stimulus
        rngState = 32'd73269;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_hole_num = '0;
        in_hole_suit = '0;
        in_pub_num = '0;
        in_pub_suit = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // idle before the first deal
        repeat (3) @(negedge clk);
        compareValid(out_valid, 1'b0);
        for (int p = 0; p < NumPlayers; p++) begin
            compareRate(p, out_win_rate[7*p +: 7], '0);
        end

        // three aces on the board and the fourth with player 0
        deal = '0;
        deal[5:0] = 6'd51;
        deal[11:6] = 6'd11;
        for (int k = 0; k < 16; k++) begin
            deal[6*(k+2) +: 6] = (k < 11) ? 6'(k) : 6'(k + 2);
        end
        deal[6*NumHole +: 6] = 6'd12;
        deal[6*(NumHole+1) +: 6] = 6'd25;
        deal[6*(NumHole+2) +: 6] = 6'd38;
        playDeal(deal);

        repeat (18) begin
            makeDeal(deal);
            playDeal(deal);
        end

        // second pulse mid-sweep must be dropped
        makeDeal(deal);
        makeDeal(other);
        sendDeal(deal);
        queueResult(deal);
        repeat (100) @(negedge clk);
        sendDeal(other);
        wait (resultCount == sentCount);

        // long enough for a late second result to show up
        repeat (Latency + 4) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule
